// File: verilog/mem_cfg_pkg.sv
/*
 * Size and address-field constants for the data-side memory front end.
 * The TLB, the L1 arrays, the controller and the top level all take
 * their widths from here through scoped names.
 */

`default_nettype none

package mem_cfg_pkg;

    // ==================================================================
    // Address translation
    // ==================================================================
    localparam int unsigned VADDR_W       = 32;
    localparam int unsigned PADDR_W       = 24;
    localparam int unsigned PAGE_OFFSET_W = 12;  // 4 KB pages
    localparam int unsigned VPN_W         = 20;
    localparam int unsigned PPN_W         = 12;
    localparam int unsigned TLB_IDX_W     = 4;   // 16 direct-indexed entries

    // ==================================================================
    // L1 data cache, one 64-bit word per line
    // ==================================================================
    localparam int unsigned DATA_W        = 64;
    localparam int unsigned WORD_OFFSET_W = 3;   // Byte bits inside a word
    localparam int unsigned SET_IDX_W     = 4;   // paddr[6:3]
    localparam int unsigned TAG_W         = 17;  // paddr[23:7]
    localparam int unsigned NUM_WAYS      = 2;

endpackage

`default_nettype wire

// File: verilog/mem_types_pkg.sv
/*
 * Response status encoding and TLB permission field layout.
 * Shared by the TLB, the cache controller and the top level.
 */

`default_nettype none

package mem_types_pkg;

    // Outcome of one request
    typedef enum logic [1:0] {
        STATUS_OK         = 2'd0,
        STATUS_TLB_MISS   = 2'd1,
        STATUS_PERM_FAULT = 2'd2
    } resp_status_t;

    // ==================================================================
    // Permission field of a TLB entry
    // ==================================================================
    localparam int unsigned PERM_W     = 3;
    localparam int unsigned PERM_READ  = 0;  // Loads allowed
    localparam int unsigned PERM_WRITE = 1;  // Stores allowed
    localparam int unsigned PERM_USER  = 2;  // User mode may touch the page

endpackage

`default_nettype wire

// File: verilog/dtlb.sv
/*
 * Direct-indexed data TLB with 16 entries.
 * Lookup and the permission check are combinational; entries are
 * written from the fill port and take effect on the next edge.
 */

`timescale 1ns/100ps
`default_nettype none

module dtlb (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [mem_cfg_pkg::VADDR_W-1:0]      lookup_vaddr,
    input  logic                                 lookup_write,
    input  logic                                 lookup_user,
    input  logic                                 tlb_wr_en,
    input  logic [mem_cfg_pkg::VPN_W-1:0]        tlb_wr_vpn,
    input  logic [mem_cfg_pkg::PPN_W-1:0]        tlb_wr_ppn,
    input  logic [mem_types_pkg::PERM_W-1:0]     tlb_wr_perm,
    output logic [mem_cfg_pkg::PADDR_W-1:0]      lookup_paddr,
    output mem_types_pkg::resp_status_t          lookup_status
);

    // Entry storage
    logic [2**mem_cfg_pkg::TLB_IDX_W-1:0] valid_q;
    logic [mem_cfg_pkg::VPN_W-1:0]        vpn_q  [2**mem_cfg_pkg::TLB_IDX_W];
    logic [mem_cfg_pkg::PPN_W-1:0]        ppn_q  [2**mem_cfg_pkg::TLB_IDX_W];
    logic [mem_types_pkg::PERM_W-1:0]     perm_q [2**mem_cfg_pkg::TLB_IDX_W];

    logic [mem_cfg_pkg::VPN_W-1:0]     vpn;
    logic [mem_cfg_pkg::TLB_IDX_W-1:0] rd_idx;
    logic [mem_cfg_pkg::TLB_IDX_W-1:0] wr_idx;
    logic [mem_types_pkg::PERM_W-1:0]  perm;
    logic                              perm_bad;

    assign vpn    = lookup_vaddr[mem_cfg_pkg::VADDR_W-1:mem_cfg_pkg::PAGE_OFFSET_W];
    assign rd_idx = vpn[mem_cfg_pkg::TLB_IDX_W-1:0];
    assign wr_idx = tlb_wr_vpn[mem_cfg_pkg::TLB_IDX_W-1:0];
    assign perm   = perm_q[rd_idx];

    // ==================================================================
    // Fill
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (tlb_wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_wr_en) begin
            vpn_q[wr_idx]  <= tlb_wr_vpn;
            ppn_q[wr_idx]  <= tlb_wr_ppn;
            perm_q[wr_idx] <= tlb_wr_perm;
        end
    end

    // ==================================================================
    // Lookup and permission check
    // ==================================================================
    assign perm_bad = (lookup_write ? !perm[mem_types_pkg::PERM_WRITE]
                                    : !perm[mem_types_pkg::PERM_READ])
                    || (lookup_user && !perm[mem_types_pkg::PERM_USER]);

    always_comb begin
        if (!valid_q[rd_idx] || (vpn_q[rd_idx] != vpn)) begin
            lookup_status = mem_types_pkg::STATUS_TLB_MISS;
        end else if (perm_bad) begin
            lookup_status = mem_types_pkg::STATUS_PERM_FAULT;
        end else begin
            lookup_status = mem_types_pkg::STATUS_OK;
        end
    end

    // PPN joined to the in-page offset
    assign lookup_paddr = {ppn_q[rd_idx], lookup_vaddr[mem_cfg_pkg::PAGE_OFFSET_W-1:0]};

endmodule

`default_nettype wire

// File: verilog/l1_dcache_arrays.sv
/*
 * Storage of the 2-way L1 data cache: tags, valid bits, data words and
 * one LRU bit per set. Reads and hit detection are combinational; fills
 * and hit updates are written on the clock edge.
 */

`timescale 1ns/100ps
`default_nettype none

module l1_dcache_arrays (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [mem_cfg_pkg::PADDR_W-1:0]    paddr,
    input  logic                               fill_en,
    input  logic                               update_en,
    input  logic [mem_cfg_pkg::DATA_W-1:0]     wdata,
    output logic                               hit,
    output logic [mem_cfg_pkg::DATA_W-1:0]     hit_data
);

    // ==================================================================
    // Storage
    // ==================================================================
    logic [mem_cfg_pkg::NUM_WAYS-1:0][2**mem_cfg_pkg::SET_IDX_W-1:0] valid_q;
    logic [2**mem_cfg_pkg::SET_IDX_W-1:0] lru_q;  // Set bit points at the LRU way

    logic [mem_cfg_pkg::TAG_W-1:0]
        tag_q  [mem_cfg_pkg::NUM_WAYS][2**mem_cfg_pkg::SET_IDX_W];
    logic [mem_cfg_pkg::DATA_W-1:0]
        data_q [mem_cfg_pkg::NUM_WAYS][2**mem_cfg_pkg::SET_IDX_W];

    logic [mem_cfg_pkg::SET_IDX_W-1:0] set_idx;
    logic [mem_cfg_pkg::TAG_W-1:0]     tag;
    logic                              hit_way;
    logic                              fill_way;

    assign set_idx  = paddr[mem_cfg_pkg::WORD_OFFSET_W +: mem_cfg_pkg::SET_IDX_W];
    assign tag      = paddr[mem_cfg_pkg::WORD_OFFSET_W + mem_cfg_pkg::SET_IDX_W +:
                            mem_cfg_pkg::TAG_W];
    assign fill_way = lru_q[set_idx];

    // ==================================================================
    // Hit detection
    // ==================================================================
    always_comb begin
        hit     = 1'b0;
        hit_way = 1'b0;
        for (int w = 0; w < mem_cfg_pkg::NUM_WAYS; w++) begin
            if (valid_q[w][set_idx] && (tag_q[w][set_idx] == tag)) begin
                hit     = 1'b1;
                hit_way = w[0];
            end
        end
    end

    assign hit_data = data_q[hit_way][set_idx];

    // ==================================================================
    // Valid and LRU state
    // ==================================================================
    // A hit on the presented address keeps its way most recent
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            lru_q   <= '0;
        end else if (fill_en) begin
            valid_q[fill_way][set_idx] <= 1'b1;
            lru_q[set_idx]             <= ~fill_way;
        end else if (hit) begin
            lru_q[set_idx] <= ~hit_way;
        end
    end

    // Line contents
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[fill_way][set_idx]  <= tag;
            data_q[fill_way][set_idx] <= wdata;
        end else if (update_en && hit) begin
            data_q[hit_way][set_idx] <= wdata;  // Write-through hit
        end
    end

endmodule

`default_nettype wire

// File: verilog/l1_dcache_ctrl.sv
/*
 * Request and memory-port controller of the L1 data cache.
 * Accepts one request at a time, looks it up in the TLB and the arrays,
 * fills read misses from memory, writes every store through, and
 * returns a one-cycle response.
 */

`timescale 1ns/100ps
`default_nettype none

module l1_dcache_ctrl (
    input  logic                               clk,
    input  logic                               rst_n,
    // Request and response
    input  logic                               req_valid,
    input  logic                               req_write,
    input  logic                               req_user,
    input  logic [mem_cfg_pkg::VADDR_W-1:0]    req_vaddr,
    input  logic [mem_cfg_pkg::DATA_W-1:0]     req_wdata,
    output logic                               req_ready,
    output logic                               resp_valid,
    output mem_types_pkg::resp_status_t        resp_status,
    output logic                               resp_hit,
    output logic [mem_cfg_pkg::DATA_W-1:0]     resp_rdata,
    // TLB
    output logic [mem_cfg_pkg::VADDR_W-1:0]    lookup_vaddr,
    output logic                               lookup_write,
    output logic                               lookup_user,
    input  logic [mem_cfg_pkg::PADDR_W-1:0]    tlb_paddr,
    input  mem_types_pkg::resp_status_t        tlb_status,
    // Cache arrays
    output logic [mem_cfg_pkg::PADDR_W-1:0]    cache_paddr,
    output logic                               fill_en,
    output logic                               update_en,
    output logic [mem_cfg_pkg::DATA_W-1:0]     cache_wdata,
    input  logic                               cache_hit,
    input  logic [mem_cfg_pkg::DATA_W-1:0]     cache_hit_data,
    // Memory port
    output logic                               mem_req,
    output logic                               mem_write,
    output logic [mem_cfg_pkg::PADDR_W-1:0]    mem_addr,
    output logic [mem_cfg_pkg::DATA_W-1:0]     mem_wdata,
    input  logic [mem_cfg_pkg::DATA_W-1:0]     mem_rdata,
    input  logic                               mem_ack
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MEM_WAIT,
        RESPOND
    } ctrl_state_t;

    ctrl_state_t state_q;

    // Accepted request
    logic [mem_cfg_pkg::VADDR_W-1:0] vaddr_q;
    logic [mem_cfg_pkg::DATA_W-1:0]  wdata_q;
    logic                            write_q;
    logic                            user_q;

    logic mem_req_q;
    logic tlb_ok;
    logic read_hit;

    assign tlb_ok   = (tlb_status == mem_types_pkg::STATUS_OK);
    assign read_hit = tlb_ok && !write_q && cache_hit;

    // ==================================================================
    // State machine
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            mem_req_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_valid) state_q <= LOOKUP;
                end
                LOOKUP: begin
                    if (!tlb_ok || read_hit) begin
                        state_q <= RESPOND;  // Fault or read hit, no memory access
                    end else begin
                        state_q   <= MEM_WAIT;
                        mem_req_q <= 1'b1;
                    end
                end
                MEM_WAIT: begin
                    if (mem_ack) begin
                        state_q   <= RESPOND;
                        mem_req_q <= 1'b0;
                    end
                end
                default: state_q <= IDLE;  // RESPOND
            endcase
        end
    end

    // ==================================================================
    // Request and response registers
    // ==================================================================
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            vaddr_q <= req_vaddr;
            wdata_q <= req_wdata;
            write_q <= req_write;
            user_q  <= req_user;
        end
        if (state_q == LOOKUP) begin
            resp_status <= tlb_status;
            resp_hit    <= tlb_ok && cache_hit;
            resp_rdata  <= read_hit ? cache_hit_data : '0;
        end else if ((state_q == MEM_WAIT) && mem_ack && !write_q) begin
            resp_rdata  <= mem_rdata;   // Read miss data
        end
    end

    assign req_ready  = (state_q == IDLE);
    assign resp_valid = (state_q == RESPOND);

    // TLB side
    assign lookup_vaddr = vaddr_q;
    assign lookup_write = write_q;
    assign lookup_user  = user_q;

    // Arrays side
    assign cache_paddr = tlb_paddr;
    assign update_en   = (state_q == LOOKUP) && tlb_ok && write_q && cache_hit;
    assign fill_en     = (state_q == MEM_WAIT) && mem_ack && !write_q;
    assign cache_wdata = write_q ? wdata_q : mem_rdata;

    // Memory port, address and data held by the request registers
    assign mem_req   = mem_req_q;
    assign mem_write = write_q;
    assign mem_addr  = tlb_paddr;
    assign mem_wdata = wdata_q;

endmodule

`default_nettype wire

// File: verilog/mem_subsys_top.sv
/*
 * Top level of the data-side memory front end.
 * Connects the data TLB, the L1 data cache arrays and the cache
 * controller; requests enter here and misses leave on the memory port.
 */

`timescale 1ns/100ps
`default_nettype none

module mem_subsys_top (
    input  logic                               clk,
    input  logic                               rst_n,
    // Request and response
    input  logic                               req_valid,
    input  logic                               req_write,
    input  logic                               req_user,
    input  logic [mem_cfg_pkg::VADDR_W-1:0]    req_vaddr,
    input  logic [mem_cfg_pkg::DATA_W-1:0]     req_wdata,
    output logic                               req_ready,
    output logic                               resp_valid,
    output mem_types_pkg::resp_status_t        resp_status,
    output logic                               resp_hit,
    output logic [mem_cfg_pkg::DATA_W-1:0]     resp_rdata,
    // Memory port
    output logic                               mem_req,
    output logic                               mem_write,
    output logic [mem_cfg_pkg::PADDR_W-1:0]    mem_addr,
    output logic [mem_cfg_pkg::DATA_W-1:0]     mem_wdata,
    input  logic [mem_cfg_pkg::DATA_W-1:0]     mem_rdata,
    input  logic                               mem_ack,
    // TLB fill
    input  logic                               tlb_wr_en,
    input  logic [mem_cfg_pkg::VPN_W-1:0]      tlb_wr_vpn,
    input  logic [mem_cfg_pkg::PPN_W-1:0]      tlb_wr_ppn,
    input  logic [mem_types_pkg::PERM_W-1:0]   tlb_wr_perm
);

    logic [mem_cfg_pkg::VADDR_W-1:0] lookup_vaddr;
    logic                            lookup_write;
    logic                            lookup_user;
    logic [mem_cfg_pkg::PADDR_W-1:0] tlb_paddr;
    mem_types_pkg::resp_status_t     tlb_status;

    logic [mem_cfg_pkg::PADDR_W-1:0] cache_paddr;
    logic                            fill_en;
    logic                            update_en;
    logic [mem_cfg_pkg::DATA_W-1:0]  cache_wdata;
    logic                            cache_hit;
    logic [mem_cfg_pkg::DATA_W-1:0]  cache_hit_data;

    dtlb u_dtlb (
        .clk           (clk),
        .rst_n         (rst_n),
        .lookup_vaddr  (lookup_vaddr),
        .lookup_write  (lookup_write),
        .lookup_user   (lookup_user),
        .tlb_wr_en     (tlb_wr_en),
        .tlb_wr_vpn    (tlb_wr_vpn),
        .tlb_wr_ppn    (tlb_wr_ppn),
        .tlb_wr_perm   (tlb_wr_perm),
        .lookup_paddr  (tlb_paddr),
        .lookup_status (tlb_status)
    );

    l1_dcache_arrays u_arrays (
        .clk       (clk),
        .rst_n     (rst_n),
        .paddr     (cache_paddr),
        .fill_en   (fill_en),
        .update_en (update_en),
        .wdata     (cache_wdata),
        .hit       (cache_hit),
        .hit_data  (cache_hit_data)
    );

    l1_dcache_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_write      (req_write),
        .req_user       (req_user),
        .req_vaddr      (req_vaddr),
        .req_wdata      (req_wdata),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp_status    (resp_status),
        .resp_hit       (resp_hit),
        .resp_rdata     (resp_rdata),
        .lookup_vaddr   (lookup_vaddr),
        .lookup_write   (lookup_write),
        .lookup_user    (lookup_user),
        .tlb_paddr      (tlb_paddr),
        .tlb_status     (tlb_status),
        .cache_paddr    (cache_paddr),
        .fill_en        (fill_en),
        .update_en      (update_en),
        .cache_wdata    (cache_wdata),
        .cache_hit      (cache_hit),
        .cache_hit_data (cache_hit_data),
        .mem_req        (mem_req),
        .mem_write      (mem_write),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_rdata      (mem_rdata),
        .mem_ack        (mem_ack)
    );

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
/*
 * Clock and reset source for the testbench.
 * 10 ns clock, rst_n held low for the first 4 rising edges.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/tb_mem_subsys.sv
/*
 * Testbench of the data-side memory front end. Fills the TLB, runs
 * directed and LFSR-driven requests against a memory model with a random
 * acknowledge delay, and checks every response with a reference model.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsys;

    localparam int WAIT_LIMIT = 40;  // Cycles allowed for any single wait

    logic clk, rst_n;
    logic req_valid, req_write, req_user, req_ready, resp_valid, resp_hit;
    logic [mem_cfg_pkg::VADDR_W-1:0] req_vaddr;
    logic [mem_cfg_pkg::DATA_W-1:0]  req_wdata, resp_rdata, mem_wdata, mem_rdata;
    mem_types_pkg::resp_status_t     resp_status;
    logic                            mem_req, mem_write, mem_ack, tlb_wr_en;
    logic [mem_cfg_pkg::PADDR_W-1:0] mem_addr;
    logic [mem_cfg_pkg::VPN_W-1:0]   tlb_wr_vpn;
    logic [mem_cfg_pkg::PPN_W-1:0]   tlb_wr_ppn;
    logic [mem_types_pkg::PERM_W-1:0] tlb_wr_perm;

    // Reference model: TLB copy, cache tags and LRU, memory contents
    logic        ref_valid [16];
    logic [19:0] ref_vpn [16];
    logic [11:0] ref_ppn [16];
    logic [2:0]  ref_perm [16];
    logic        way_valid [2][16];
    logic [16:0] way_tag [2][16];
    logic        lru [16];        // Least recently used way per set
    logic [63:0] mem_words [2048];

    mem_types_pkg::resp_status_t exp_status;
    logic        exp_hit, exp_write, exp_no_mem, exp_check_data;
    logic [63:0] exp_rdata;
    logic [63:0] exp_wdata;
    logic [23:0] exp_paddr;

    logic        prev_req, prev_ack, prev_write;
    logic [23:0] prev_addr;
    logic [63:0] prev_wdata;
    int          cycle = 0;
    int          accept_cyc = 0;
    int          ack_wait = 0;
    int          error_count = 0;
    int          test_base = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [15:0] stim_lfsr = 16'd40;
    logic [15:0] delay_lfsr = 16'd40;

    tb_clock_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    mem_subsys_top uut (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_write(req_write), .req_user(req_user),
        .req_vaddr(req_vaddr), .req_wdata(req_wdata), .req_ready(req_ready),
        .resp_valid(resp_valid), .resp_status(resp_status), .resp_hit(resp_hit),
        .resp_rdata(resp_rdata),
        .mem_req(mem_req), .mem_write(mem_write), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ack(mem_ack),
        .tlb_wr_en(tlb_wr_en), .tlb_wr_vpn(tlb_wr_vpn), .tlb_wr_ppn(tlb_wr_ppn),
        .tlb_wr_perm(tlb_wr_perm)
    );

    // 16-bit Galois LFSR, one step per random bit
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // Four pages of 512 words, page slot from PPN bits 1:0
    function automatic int mem_index(input logic [23:0] paddr);
        mem_index = {paddr[13:12], paddr[11:3]};
    endfunction

    function automatic logic [63:0] fill_word(input int idx);
        fill_word = {idx[15:0] ^ 16'ha5c3, 16'h0f1e, ~idx[15:0], idx[15:0] + 16'h3c00};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], stim_lfsr[0]};
            stim_lfsr = lfsr_step(stim_lfsr);
        end
    endtask

    task automatic value_error(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        $display("ERROR %s: got %h expected %h", name, got, want);
        error_count++;
    endtask

    task automatic rule_error(input string what);
        $display("%0t ns: %s", $time, what);
        error_count++;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s", what);
        $display("Test FAILED");
        $finish;
    endtask

    // ==================================================================
    // Memory model, acknowledges after 1 to 4 cycles
    // ==================================================================
    always @(posedge clk) begin : mem_model
        logic [1:0] d;
        mem_ack <= 1'b0;
        if (mem_req && !mem_ack) begin
            if (ack_wait == 0) begin
                for (int i = 0; i < 2; i++) begin
                    d = {d[0], delay_lfsr[0]};
                    delay_lfsr = lfsr_step(delay_lfsr);
                end
                ack_wait <= d + 1;
            end else if (ack_wait == 1) begin
                mem_ack  <= 1'b1;
                ack_wait <= 0;
                if (mem_write) mem_words[mem_index(mem_addr)] <= mem_wdata;
                else mem_rdata <= mem_words[mem_index(mem_addr)];
            end else begin
                ack_wait <= ack_wait - 1;
            end
        end
    end

    // ==================================================================
    // Checking assertions, sampled on the rising edge
    // ==================================================================
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (rst_n) begin
            if (req_valid && req_ready) accept_cyc <= cycle;
            if (resp_valid) begin
                assert (resp_status == exp_status)
                    else value_error("resp_status", resp_status, exp_status);
                assert (resp_hit == exp_hit) else value_error("resp_hit", resp_hit, exp_hit);
                if (exp_check_data)
                    assert (resp_rdata == exp_rdata)
                        else value_error("resp_rdata", resp_rdata, exp_rdata);
                if (exp_no_mem)
                    assert (cycle - accept_cyc == 2)
                        else rule_error("fault or read-hit response not 2 cycles after accept");
            end
            assert (!(mem_req && exp_no_mem))
                else rule_error("memory request issued for a fault or a read hit");
            if (mem_req && !prev_req) begin
                assert (mem_addr == exp_paddr) else value_error("mem_addr", mem_addr, exp_paddr);
                assert (mem_write == exp_write)
                    else value_error("mem_write", mem_write, exp_write);
                if (exp_write)
                    assert (mem_wdata == exp_wdata)
                        else value_error("mem_wdata", mem_wdata, exp_wdata);
            end
            if (prev_req && !prev_ack)
                assert (mem_req && mem_addr == prev_addr && mem_write == prev_write
                        && mem_wdata == prev_wdata)
                    else rule_error("memory request dropped or changed before acknowledge");
        end
        prev_req   <= mem_req;
        prev_ack   <= mem_ack;
        prev_addr  <= mem_addr;
        prev_write <= mem_write;
        prev_wdata <= mem_wdata;
    end

    // Predicts status, hit and data, and advances the cache model
    task automatic predict(input logic write, input logic user, input logic [31:0] vaddr,
                           input logic [63:0] wdata);
        logic [19:0] vpn;
        logic [3:0]  ti;
        logic [3:0]  set;
        logic [16:0] tag;
        logic [2:0]  perm;
        int          way;
        vpn        = vaddr[31:12];
        ti         = vpn[3:0];
        perm       = ref_perm[ti];
        exp_paddr  = {ref_ppn[ti], vaddr[11:0]};
        set        = exp_paddr[6:3];
        tag        = exp_paddr[23:7];
        exp_hit    = 1'b0;
        exp_write  = write;
        exp_wdata  = wdata;
        if (!ref_valid[ti] || ref_vpn[ti] != vpn) begin
            exp_status = mem_types_pkg::STATUS_TLB_MISS;
        end else if ((write && !perm[mem_types_pkg::PERM_WRITE])
                     || (!write && !perm[mem_types_pkg::PERM_READ])
                     || (user && !perm[mem_types_pkg::PERM_USER])) begin
            exp_status = mem_types_pkg::STATUS_PERM_FAULT;
        end else begin
            exp_status = mem_types_pkg::STATUS_OK;
        end
        exp_no_mem     = (exp_status != mem_types_pkg::STATUS_OK);
        exp_check_data = 1'b0;
        if (exp_status == mem_types_pkg::STATUS_OK) begin
            way = -1;
            for (int w = 0; w < 2; w++)
                if (way_valid[w][set] && way_tag[w][set] == tag) way = w;
            if (way >= 0) begin
                exp_hit  = 1'b1;
                lru[set] = (way == 0);  // The other way becomes LRU
            end else if (!write) begin
                way_valid[lru[set]][set] = 1'b1;  // Fill the LRU way
                way_tag[lru[set]][set]   = tag;
                lru[set]                 = ~lru[set];
            end
            exp_no_mem     = !write && (way >= 0);
            exp_check_data = !write;
            exp_rdata      = mem_words[mem_index(exp_paddr)];
        end
    endtask

    task automatic issue(input logic write, input logic user, input logic [31:0] vaddr,
                         input logic [63:0] wdata);
        int n;
        @(posedge clk);
        predict(write, user, vaddr, wdata);
        req_valid <= 1'b1;
        req_write <= write;
        req_user  <= user;
        req_vaddr <= vaddr;
        req_wdata <= wdata;
        n = 0;
        @(posedge clk);
        while (!req_ready) begin
            n++;
            if (n > WAIT_LIMIT) stop_on_timeout("request was never accepted");
            @(posedge clk);
        end
        req_valid <= 1'b0;
        n = 0;
        @(posedge clk);
        while (!resp_valid) begin
            n++;
            if (n > WAIT_LIMIT) stop_on_timeout("no response to an accepted request");
            @(posedge clk);
        end
    endtask

    task automatic fill_tlb(input logic [19:0] vpn, input logic [11:0] ppn,
                            input logic [2:0] perm);
        @(posedge clk);
        tlb_wr_en   <= 1'b1;
        tlb_wr_vpn  <= vpn;
        tlb_wr_ppn  <= ppn;
        tlb_wr_perm <= perm;
        ref_valid[vpn[3:0]] = 1'b1;
        ref_vpn[vpn[3:0]]   = vpn;
        ref_ppn[vpn[3:0]]   = ppn;
        ref_perm[vpn[3:0]]  = perm;
        @(posedge clk);
        tlb_wr_en <= 1'b0;
    endtask

    task automatic end_test(input string name);
        @(posedge clk);
        tests_run++;
        if (error_count == test_base) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, error_count - test_base);
        end
        test_base = error_count;
    endtask

    // ==================================================================
    // Test sequence
    // ==================================================================
    initial begin : stimulus
        logic [31:0] r;
        logic [31:0] d;
        int          n;
        req_valid <= 1'b0;
        req_write <= 1'b0;
        req_user  <= 1'b0;
        req_vaddr <= '0;
        req_wdata <= '0;
        mem_ack   <= 1'b0;
        mem_rdata <= '0;
        tlb_wr_en <= 1'b0;
        tlb_wr_vpn  <= '0;
        tlb_wr_ppn  <= '0;
        tlb_wr_perm <= '0;
        exp_no_mem  = 1'b0;
        for (int i = 0; i < 2048; i++) mem_words[i] = fill_word(i);
        for (int s = 0; s < 16; s++) begin
            ref_valid[s]    = 1'b0;
            way_valid[0][s] = 1'b0;
            way_valid[1][s] = 1'b0;
            lru[s]          = 1'b0;
        end
        n = 0;
        while (rst_n !== 1'b1) begin
            n++;
            if (n > WAIT_LIMIT) stop_on_timeout("reset never released");
            @(posedge clk);
        end
        @(posedge clk);
        assert (req_ready === 1'b1 && resp_valid === 1'b0 && mem_req === 1'b0)
            else rule_error("outputs not idle after reset");
        issue(1'b0, 1'b0, 32'h0002_5010, '0);  // Unfilled page
        end_test("reset");

        fill_tlb(20'h00010, 12'h021, 3'b111);
        fill_tlb(20'h00011, 12'h036, 3'b101);  // No write
        fill_tlb(20'h00012, 12'h047, 3'b011);  // Supervisor only
        fill_tlb(20'h00013, 12'h058, 3'b111);
        issue(1'b1, 1'b0, 32'h0001_1020, 64'h0bad_0bad_0bad_0bad);
        issue(1'b0, 1'b1, 32'h0001_2020, '0);
        issue(1'b0, 1'b0, 32'h0001_1018, '0);
        end_test("permissions");

        issue(1'b0, 1'b0, 32'h0001_0010, '0);
        issue(1'b0, 1'b0, 32'h0001_0010, '0);
        end_test("read_miss_then_hit");

        issue(1'b1, 1'b0, 32'h0001_0010, 64'h1122_3344_5566_7788);
        issue(1'b0, 1'b0, 32'h0001_0010, '0);
        issue(1'b1, 1'b0, 32'h0001_0230, 64'hcafe_f00d_1234_abcd);
        issue(1'b0, 1'b0, 32'h0001_0230, '0);
        end_test("write_through");

        // A, B, A, C in set 9, then A and B again
        issue(1'b0, 1'b0, 32'h0001_3048, '0);
        issue(1'b0, 1'b0, 32'h0001_30c8, '0);
        issue(1'b0, 1'b0, 32'h0001_3048, '0);
        issue(1'b0, 1'b0, 32'h0001_3148, '0);
        issue(1'b0, 1'b0, 32'h0001_3048, '0);
        issue(1'b0, 1'b0, 32'h0001_30c8, '0);
        end_test("lru_replacement");

        for (int k = 0; k < 40; k++) begin
            rand_bits(9, r);
            rand_bits(32, d);
            issue(r[7], r[8], {r[0] ? 20'h00013 : 20'h00010, 3'b000, r[2:1], r[6:3], 3'b000},
                  {d, ~d});
        end
        end_test("random_traffic");

        $display("Tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
verilog/mem_cfg_pkg.sv
verilog/mem_types_pkg.sv
verilog/dtlb.sv
verilog/l1_dcache_arrays.sv
verilog/l1_dcache_ctrl.sv
verilog/mem_subsys_top.sv
dv/tb_clock_gen.sv
dv/tb_mem_subsys.sv
